/* verilog.f */
src/hdc_pkg.sv
src/fe_id_if.sv
src/stage_reg.sv
src/fetch_stage.sv
src/decoder.sv
src/id_stage.sv
src/frontend_top.sv
test/frontend_asserts.sv
test/tb_frontend.sv

/* Bender.yml */
package:
  name: rv32i_frontend

sources:
  - src/hdc_pkg.sv
  - src/fe_id_if.sv
  - src/stage_reg.sv
  - src/fetch_stage.sv
  - src/decoder.sv
  - src/id_stage.sv
  - src/frontend_top.sv
  - target: test
    files:
      - test/frontend_asserts.sv
      - test/tb_frontend.sv

/* test/tb_frontend.sv */
//======================================================================
// Testbench for the RV32I front end: Wishbone memory model, reference
// decoder, directed tests, stall and sequence monitor, watchdog
//======================================================================

`timescale 1ns/100ps

module tb_frontend;

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] START_PC   = 32'h100;
    localparam int          N_STALL    = 24;
    localparam int          N_WORDS    = 60;        // Words checked over all tests
    localparam logic [31:0] ERR_LO     = 32'h800;   // Bus error window
    localparam logic [31:0] ERR_HI     = 32'h808;
    localparam logic [31:0] ERR_DATA   = 32'h0;     // Data driven with err

    logic           clk = 1'b0;
    logic           rst_n;
    wire            wb_cyc_o;
    wire            wb_stb_o;
    wire            wb_we_o;
    wire [31:0]     wb_adr_o;
    wire [3:0]      wb_sel_o;
    logic [31:0]    wb_dat_i;
    logic           wb_ack_i;
    logic           wb_err_i;
    logic           stall;
    logic           flush;
    logic [31:0]    flush_pc;
    wire            op_valid;
    wire hdc_pkg::idop_t op;

    logic [31:0]    mem [0:1023];
    hdc_pkg::idop_t exp_q[$];       // Expected ID/OP entries in order
    hdc_pkg::idop_t held_op;
    logic           hold_q = 1'b0;
    logic [31:0]    next_pc;
    integer         seed = 84;
    int             errors = 0;
    int             n_checked = 0;
    int             n_illegal = 0;
    int             n_buserr = 0;
    int             ack_wait;
    logic           req_open = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    frontend_top #(.RESET_PC(START_PC)) u_dut (
        .s_clk_i      (clk),
        .rst_n_i      (rst_n),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_sel_o     (wb_sel_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .wb_err_i     (wb_err_i),
        .stall_i      (stall),
        .flush_i      (flush),
        .flush_pc_i   (flush_pc),
        .op_valid_o   (op_valid),
        .op_pc_o      (op.pc),
        .op_rd_o      (op.rd),
        .op_rs1_o     (op.rs1),
        .op_rs2_o     (op.rs2),
        .op_f_o       (op.f),
        .op_imm_o     (op.imm),
        .op_sctrl_o   (op.sctrl),
        .op_ictrl_o   (op.ictrl),
        .op_imiscon_o (op.imiscon)
    );

    function automatic logic in_err_range(input logic [31:0] addr);
        return (addr >= ERR_LO) && (addr < ERR_HI);
    endfunction

    // Expected ID/OP entry from the RV32I format rules
    function automatic hdc_pkg::idop_t ref_decode(input logic [31:0] w, input logic [31:0] pc,
                                                  input logic berr);
        hdc_pkg::idop_t e;
        e         = '0;
        e.pc      = pc;
        e.rd      = w[11:7];
        e.rs1     = w[19:15];
        e.rs2     = w[24:20];
        e.f       = {1'b0, w[14:12]};
        e.imiscon = hdc_pkg::IMISCON_FREE;
        case (w[6:0])
            hdc_pkg::OPC_LUI, hdc_pkg::OPC_AUIPC: begin
                e.imm   = {w[31:12], 12'h000};
                e.sctrl = 3'b100;
                e.ictrl = 7'b1100000;   // UPPER, RD
            end
            hdc_pkg::OPC_JAL: begin
                e.imm   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                e.sctrl = 3'b100;
                e.ictrl = 7'b1010000;   // JUMP, RD
            end
            hdc_pkg::OPC_JALR: begin
                e.imm   = {{21{w[31]}}, w[30:20]};
                e.sctrl = 3'b101;
                e.ictrl = 7'b1010000;
            end
            hdc_pkg::OPC_BRANCH: begin
                e.imm   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                e.sctrl = 3'b111;
                e.ictrl = 7'b0001000;
            end
            hdc_pkg::OPC_LOAD: begin
                e.imm   = {{21{w[31]}}, w[30:20]};
                e.sctrl = 3'b101;
                e.ictrl = 7'b1000010;
            end
            hdc_pkg::OPC_STORE: begin
                e.imm   = {{21{w[31]}}, w[30:25], w[11:7]};
                e.sctrl = 3'b111;
                e.ictrl = 7'b0000100;
            end
            hdc_pkg::OPC_OPIMM: begin
                e.imm   = {{21{w[31]}}, w[30:20]};
                e.sctrl = 3'b101;
                e.ictrl = 7'b1000001;
                if (w[13:12] == 2'b01) begin
                    e.f[3] = w[30];     // SLLI, SRLI, SRAI
                end
            end
            hdc_pkg::OPC_OP: begin
                e.f[3]  = w[30];
                e.sctrl = 3'b011;
                e.ictrl = 7'b1000001;
            end
            default: e.imiscon = hdc_pkg::IMISCON_ILLEGAL;
        endcase
        if (berr) begin
            e.ictrl   = '0;
            e.imiscon = hdc_pkg::IMISCON_BUSERR;
        end
        return e;
    endfunction

    // Wishbone slave with 0 to 3 wait cycles
    always begin
        @(posedge clk);
        #10;
        wb_ack_i = 1'b0;
        wb_err_i = 1'b0;
        if (!rst_n) begin
            req_open = 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (wb_we_o !== 1'b0 || wb_sel_o !== 4'hF) begin
                errors++;
                $display("FAILED at %0t: read with we %b sel %h, expected 0 and f",
                         $time, wb_we_o, wb_sel_o);
            end
            if (!req_open) begin
                req_open = 1'b1;
                ack_wait = $unsigned($random(seed)) % 4;
            end
            if (ack_wait == 0) begin
                req_open = 1'b0;
                if (in_err_range(wb_adr_o)) begin
                    wb_err_i = 1'b1;
                    wb_dat_i = ERR_DATA;
                end else begin
                    wb_ack_i = 1'b1;
                    wb_dat_i = mem[wb_adr_o[11:2]];
                end
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    // A word is handed on at an edge with op_valid and no stall or flush
    always @(posedge clk) begin : monitor
        hdc_pkg::idop_t want;
        if (rst_n && hold_q && op !== held_op) begin
            errors++;
            $display("FAILED at %0t: ID/OP output changed while stalled", $time);
        end
        if (rst_n && op_valid && !stall && !flush) begin
            if (op.pc !== next_pc) begin
                errors++;
                $display("FAILED at %0t: pc %h handed on, expected %h", $time, op.pc, next_pc);
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                n_checked++;
                if (op !== want) begin
                    errors++;
                    $display("FAILED at %0t: pc %h got %h expected %h", $time, op.pc, op, want);
                end
            end
            if (op.imiscon == hdc_pkg::IMISCON_ILLEGAL) n_illegal++;
            if (op.imiscon == hdc_pkg::IMISCON_BUSERR) n_buserr++;
            next_pc = next_pc + 32'd4;
        end
        if (flush) next_pc = flush_pc;
        if (!rst_n) next_pc = START_PC;
        hold_q  = op_valid && stall && !flush;
        held_op = op;
    end

    task automatic expect_words(input logic [31:0] base, input int n);
        logic [31:0] pc;
        for (int i = 0; i < n; i++) begin
            pc = base + 32'd4 * i;
            if (in_err_range(pc)) begin
                exp_q.push_back(ref_decode(ERR_DATA, pc, 1'b1));
            end else begin
                exp_q.push_back(ref_decode(mem[pc[11:2]], pc, 1'b0));
            end
        end
    endtask

    task automatic wait_drain(input int n);
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < n * 10) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("Words missing: %0d expected words never reached ID/OP", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic flush_to(input logic [31:0] pc);
        flush    = 1'b1;
        flush_pc = pc;
        @(posedge clk);
        #10;
        flush = 1'b0;
    endtask

    task automatic sequential_fetch();
        expect_words(START_PC, 8);
        @(posedge clk);
        #10;
        if (!wb_cyc_o || wb_adr_o !== START_PC) begin
            errors++;
            $display("FAILED at %0t: first request at %h, expected %h", $time, wb_adr_o, START_PC);
        end
        wait_drain(8);
    endtask

    task automatic decode_formats();
        logic [31:0] words [12] = '{
            32'h123452B7, 32'hFFFFF317, 32'hFF9FF0EF, 32'h00C08067,  // LUI AUIPC JAL JALR
            32'hFE2088E3, 32'hFFC12383, 32'h0071A423, 32'hFFF48413,  // BEQ LW SW ADDI
            32'h4035D513, 32'h00E68633, 32'h411807B3, 32'h41A5D933   // SRAI ADD SUB SRA
        };
        foreach (words[i]) mem[(32'h200 >> 2) + i] = words[i];
        flush_to(32'h200);
        expect_words(32'h200, 12);
        wait_drain(12);
    endtask

    task automatic back_pressure();
        int len;
        int n;
        stall = 1'b1;              // ID/OP empty after the flush so no hold
        flush_to(32'h300);
        expect_words(32'h300, N_STALL);
        n = 0;
        while (!op_valid && n < 20) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (!op_valid) begin
            errors++;
            $display("Stall with an empty ID/OP register blocked the first word");
        end
        while (exp_q.size() > 0) begin
            stall = ($random(seed) & 1) != 0;
            len   = 1 + $unsigned($random(seed)) % 4;
            repeat (len) begin
                @(posedge clk);
                #10;
            end
        end
        stall = 1'b0;
        wait_drain(N_STALL);
    endtask

    task automatic flush_redirect();
        flush_to(32'h400);
        expect_words(32'h400, 4);
        wait_drain(4);
        // Redirect while a read is outstanding
        while (!wb_cyc_o) begin
            @(posedge clk);
            #10;
        end
        flush_to(32'h500);
        expect_words(32'h500, 6);
        while (!op_valid) begin
            @(posedge clk);
            #10;
        end
        if (op.pc !== 32'h500) begin
            errors++;
            $display("FAILED at %0t: first word after flush from %h, expected 500", $time, op.pc);
        end
        wait_drain(6);
    endtask

    task automatic misconduct_codes();
        int ill0;
        int berr0;
        mem[32'h7F8 >> 2] = 32'hFFFF_FFFF;     // Opcode 1111111 is not RV32I
        ill0  = n_illegal;
        berr0 = n_buserr;
        flush_to(32'h7F8);
        expect_words(32'h7F8, 6);           // 0x800 and 0x804 answer with err
        wait_drain(6);
        if (n_illegal != ill0 + 1 || n_buserr != berr0 + 2) begin
            errors++;
            $display("FAILED at %0t: %0d illegal and %0d bus error words, expected 1 and 2",
                     $time, n_illegal - ill0, n_buserr - berr0);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        flush_pc = 32'h0;
        wb_dat_i = 32'h0;
        wb_ack_i = 1'b0;
        wb_err_i = 1'b0;
        // ADDI fill with every index bit in the word
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {i[9:0], 2'b00, i[4:0], 3'b000, i[9:5], 7'b0010011};
        end
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        sequential_fetch();
        decode_formats();
        back_pressure();
        flush_redirect();
        misconduct_codes();

        $display("Errors: %0d, words checked: %0d", errors, n_checked);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(N_WORDS * 10 * CLK_PERIOD);
        $display("Timeout: tests did not complete within %0d ns", N_WORDS * 10 * CLK_PERIOD);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* test/frontend_asserts.sv */
//======================================================================
// Concurrent checks on the Wishbone master, stall hold and reset state
//======================================================================

`timescale 1ns/100ps

module frontend_asserts (
    input logic        s_clk_i,
    input logic        rst_n_i,
    input logic        cyc_i,
    input logic        stb_i,
    input logic [31:0] adr_i,
    input logic        ack_i,
    input logic        err_i,
    input logic        flush_i,
    input logic        stall_i,
    input logic        op_valid_i,
    input logic [31:0] op_pc_i,
    input logic [31:0] op_imm_i,
    input logic [6:0]  op_ictrl_i,
    input logic [1:0]  op_imiscon_i
);

    a_stb_in_cycle: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        stb_i |-> cyc_i)
        else $error("Wishbone stb raised outside a cycle");

    a_request_held: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        stb_i && !ack_i && !err_i |=> stb_i && $stable(adr_i))
        else $error("Wishbone request changed before ack or err");

    a_stall_hold: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        op_valid_i && stall_i && !flush_i |=>
            $stable({op_pc_i, op_imm_i, op_ictrl_i, op_imiscon_i}))
        else $error("ID/OP outputs moved under stall");

    a_reset_idle: assert property (@(posedge s_clk_i)
        !rst_n_i |=> !cyc_i && !op_valid_i)
        else $error("Bus cycle or op_valid active after reset");

endmodule

bind frontend_top frontend_asserts u_asserts (
    .s_clk_i      (s_clk_i),
    .rst_n_i      (rst_n_i),
    .cyc_i        (wb_cyc_o),
    .stb_i        (wb_stb_o),
    .adr_i        (wb_adr_o),
    .ack_i        (wb_ack_i),
    .err_i        (wb_err_i),
    .flush_i      (flush_i),
    .stall_i      (stall_i),
    .op_valid_i   (op_valid_o),
    .op_pc_i      (op_pc_o),
    .op_imm_i     (op_imm_o),
    .op_ictrl_i   (op_ictrl_o),
    .op_imiscon_i (op_imiscon_o)
);

/* src/frontend_top.sv */
//====================================================================
// Front end top level: fetch and decode with plain ports
//====================================================================

`timescale 1ns/100ps

module frontend_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                s_clk_i,
    input  logic                rst_n_i,

    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output logic [31:0]         wb_adr_o,
    output logic [3:0]          wb_sel_o,
    input  logic [31:0]         wb_dat_i,
    input  logic                wb_ack_i,
    input  logic                wb_err_i,

    input  logic                stall_i,
    input  logic                flush_i,
    input  logic [31:0]         flush_pc_i,   // New fetch address on flush

    output logic                op_valid_o,
    output logic [31:0]         op_pc_o,
    output hdc_pkg::rf_add_t    op_rd_o,
    output hdc_pkg::rf_add_t    op_rs1_o,
    output hdc_pkg::rf_add_t    op_rs2_o,
    output hdc_pkg::f_part_t    op_f_o,
    output logic [31:0]         op_imm_o,
    output hdc_pkg::sctrl_t     op_sctrl_o,
    output hdc_pkg::ictrl_t     op_ictrl_o,
    output hdc_pkg::imiscon_t   op_imiscon_o
);

    hdc_pkg::idop_t idop;

    fe_id_if u_fe_id ();

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .s_clk_i    (s_clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .flush_pc_i (flush_pc_i),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_we_o    (wb_we_o),
        .wb_adr_o   (wb_adr_o),
        .wb_sel_o   (wb_sel_o),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_i   (wb_ack_i),
        .wb_err_i   (wb_err_i),
        .fe_id      (u_fe_id.fe)
    );

    id_stage u_id (
        .s_clk_i    (s_clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .fe_id      (u_fe_id.id),
        .op_valid_o (op_valid_o),
        .op_o       (idop)
    );

    // ID/OP fields out to the operand stage
    assign op_pc_o      = idop.pc;
    assign op_rd_o      = idop.rd;
    assign op_rs1_o     = idop.rs1;
    assign op_rs2_o     = idop.rs2;
    assign op_f_o       = idop.f;
    assign op_imm_o     = idop.imm;
    assign op_sctrl_o   = idop.sctrl;
    assign op_ictrl_o   = idop.ictrl;
    assign op_imiscon_o = idop.imiscon;

endmodule

/* src/id_stage.sv */
//====================================================================
// Decode stage: decoder, stall qualification and the ID/OP register
//====================================================================

`timescale 1ns/100ps

module id_stage (
    input  logic           s_clk_i,
    input  logic           rst_n_i,
    input  logic           stall_i,     // Back-pressure from operand stage
    input  logic           flush_i,

    fe_id_if.id            fe_id,

    output logic           op_valid_o,
    output hdc_pkg::idop_t op_o
);

    hdc_pkg::idop_t dec;
    hdc_pkg::idop_t idop_w;
    logic           idop_empty;
    logic           stall_id;
    logic           idop_we;

    decoder u_decoder (
        .instr_i (fe_id.payload.instr),
        .pc_i    (fe_id.payload.pc),
        .berr_i  (fe_id.payload.berr),
        .idop_o  (dec)
    );

    // ID/OP holds nothing executable
    assign idop_empty = ~op_valid_o |
                        ((op_o.ictrl == '0) && (op_o.imiscon == hdc_pkg::IMISCON_FREE));

    // A stall only matters when there is something to hold
    assign stall_id = stall_i & ~idop_empty;

    assign idop_we    = flush_i | ~stall_id;
    assign fe_id.take = fe_id.valid & ~stall_id & ~flush_i;

    always_comb begin
        idop_w = dec;
        // Empty slot on flush or when no word is waiting
        if (flush_i || !fe_id.valid) begin
            idop_w.ictrl   = '0;
            idop_w.imiscon = hdc_pkg::IMISCON_FREE;
        end
    end

    stage_reg #(.T(hdc_pkg::idop_t)) u_idop_reg (
        .s_clk_i (s_clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (idop_we),
        .flush_i (flush_i),
        .valid_i (fe_id.valid),
        .data_i  (idop_w),
        .valid_o (op_valid_o),
        .data_o  (op_o)
    );

endmodule

/* src/decoder.sv */
//====================================================================
// Combinational RV32I decoder producing the ID/OP entry
//====================================================================

`timescale 1ns/100ps

module decoder (
    input  logic [31:0]    instr_i,
    input  logic [31:0]    pc_i,
    input  logic           berr_i,
    output hdc_pkg::idop_t idop_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        is_shift;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    // SLLI, SRLI and SRAI carry bit 30 like the R-type ops
    assign is_shift = (opcode == hdc_pkg::OPC_OPIMM) && (funct3[1:0] == 2'b01);

    // Immediate formats, sign bit is always instr[31]
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        idop_o         = '0;
        idop_o.pc      = pc_i;
        idop_o.rd      = instr_i[11:7];
        idop_o.rs1     = instr_i[19:15];
        idop_o.rs2     = instr_i[24:20];
        idop_o.f       = {1'b0, funct3};
        idop_o.imiscon = hdc_pkg::IMISCON_FREE;

        case (opcode)
            hdc_pkg::OPC_LUI, hdc_pkg::OPC_AUIPC: begin
                idop_o.imm                        = imm_u;
                idop_o.sctrl[hdc_pkg::SCTRL_IMM]  = 1'b1;
                idop_o.ictrl[hdc_pkg::ICTRL_UPPER] = 1'b1;
            end
            hdc_pkg::OPC_JAL: begin
                idop_o.imm                        = imm_j;
                idop_o.sctrl[hdc_pkg::SCTRL_IMM]  = 1'b1;
                idop_o.ictrl[hdc_pkg::ICTRL_JUMP] = 1'b1;
            end
            hdc_pkg::OPC_JALR: begin
                idop_o.imm                        = imm_i;
                idop_o.sctrl[hdc_pkg::SCTRL_RS1]  = 1'b1;
                idop_o.sctrl[hdc_pkg::SCTRL_IMM]  = 1'b1;
                idop_o.ictrl[hdc_pkg::ICTRL_JUMP] = 1'b1;
            end
            hdc_pkg::OPC_BRANCH: begin
                idop_o.imm                          = imm_b;
                idop_o.sctrl                        = '1;   // rs1, rs2 and offset
                idop_o.ictrl[hdc_pkg::ICTRL_BRANCH] = 1'b1;
            end
            hdc_pkg::OPC_LOAD: begin
                idop_o.imm                        = imm_i;
                idop_o.sctrl[hdc_pkg::SCTRL_RS1]  = 1'b1;
                idop_o.sctrl[hdc_pkg::SCTRL_IMM]  = 1'b1;
                idop_o.ictrl[hdc_pkg::ICTRL_LOAD] = 1'b1;
            end
            hdc_pkg::OPC_STORE: begin
                idop_o.imm                         = imm_s;
                idop_o.sctrl                       = '1;
                idop_o.ictrl[hdc_pkg::ICTRL_STORE] = 1'b1;
            end
            hdc_pkg::OPC_OPIMM: begin
                idop_o.imm                       = imm_i;
                idop_o.f                         = {is_shift & instr_i[30], funct3};
                idop_o.sctrl[hdc_pkg::SCTRL_RS1] = 1'b1;
                idop_o.sctrl[hdc_pkg::SCTRL_IMM] = 1'b1;
                idop_o.ictrl[hdc_pkg::ICTRL_ALU] = 1'b1;
            end
            hdc_pkg::OPC_OP: begin
                idop_o.f                         = {instr_i[30], funct3};  // SUB, SRA
                idop_o.sctrl[hdc_pkg::SCTRL_RS1] = 1'b1;
                idop_o.sctrl[hdc_pkg::SCTRL_RS2] = 1'b1;
                idop_o.ictrl[hdc_pkg::ICTRL_ALU] = 1'b1;
            end
            default: begin
                idop_o.imiscon = hdc_pkg::IMISCON_ILLEGAL;
            end
        endcase

        // Everything except store and branch writes rd
        if (idop_o.ictrl != '0 &&
            !idop_o.ictrl[hdc_pkg::ICTRL_STORE] && !idop_o.ictrl[hdc_pkg::ICTRL_BRANCH]) begin
            idop_o.ictrl[hdc_pkg::ICTRL_RD] = 1'b1;
        end

        // Bus error wins, the word itself is meaningless
        if (berr_i) begin
            idop_o.ictrl   = '0;
            idop_o.imiscon = hdc_pkg::IMISCON_BUSERR;
        end
    end

endmodule

/* src/fetch_stage.sv */
//====================================================================
// Fetch stage: program counter, Wishbone classic read master,
// flush redirect and the FE/ID register
//====================================================================

`timescale 1ns/100ps

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        s_clk_i,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  logic [31:0] flush_pc_i,

    // Wishbone classic master
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output logic [31:0] wb_adr_o,
    output logic [3:0]  wb_sel_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i,
    input  logic        wb_err_i,

    fe_id_if.fe         fe_id
);

    logic [31:0]    pc_q;
    logic [31:0]    adr_q;      // Bus address held for the open cycle
    logic           busy_q;     // Bus cycle open
    logic           drop_q;     // Open cycle was flushed so its data is dropped
    logic           bus_done;
    logic           accept;
    logic           slot_free;
    logic           issue;
    logic           feid_we;
    hdc_pkg::feid_t feid_w;

    assign bus_done  = busy_q & (wb_ack_i | wb_err_i);
    assign accept    = bus_done & ~drop_q & ~flush_i;     // Response goes into FE/ID
    // FE/ID empty now or its word leaves on this edge
    assign slot_free = ~fe_id.valid | fe_id.take;
    assign issue     = ~busy_q & (flush_i | slot_free);

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            pc_q   <= RESET_PC;
            adr_q  <= RESET_PC;
            busy_q <= 1'b0;
            drop_q <= 1'b0;
        end else begin
            if (flush_i) begin
                pc_q <= flush_pc_i;             // Redirect at once
            end else if (accept) begin
                pc_q <= pc_q + 32'd4;
            end

            if (bus_done) begin
                busy_q <= 1'b0;
            end else if (issue) begin
                busy_q <= 1'b1;
                adr_q  <= flush_i ? flush_pc_i : pc_q;
            end

            // A flush while waiting keeps the cycle open but marks it stale
            if (bus_done) begin
                drop_q <= 1'b0;
            end else if (flush_i && busy_q) begin
                drop_q <= 1'b1;
            end
        end
    end

    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;
    assign wb_we_o  = 1'b0;         // Read only
    assign wb_adr_o = adr_q;
    assign wb_sel_o = 4'hF;

    assign feid_w  = '{pc: pc_q, instr: wb_dat_i, berr: wb_err_i};
    assign feid_we = accept | (fe_id.valid & fe_id.take);

    stage_reg #(.T(hdc_pkg::feid_t)) u_feid_reg (
        .s_clk_i (s_clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (feid_we),
        .flush_i (flush_i),
        .valid_i (accept),
        .data_i  (feid_w),
        .valid_o (fe_id.valid),
        .data_o  (fe_id.payload)
    );

endmodule

/* src/stage_reg.sv */
//====================================================================
// Generic pipeline register with valid bit, write enable and flush
//====================================================================

`timescale 1ns/100ps

module stage_reg #(
    parameter type T = logic
) (
    input  logic s_clk_i,
    input  logic rst_n_i,
    input  logic we_i,
    input  logic flush_i,
    input  logic valid_i,
    input  T     data_i,
    output logic valid_o,
    output T     data_o
);

    logic valid_q;
    T     data_q;

    // Valid clears on reset and flush
    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (we_i) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (we_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

/* src/fe_id_if.sv */
//====================================================================
// Fetch to decode handoff: FE/ID word, valid and take
//====================================================================

`timescale 1ns/100ps

interface fe_id_if;

    logic          valid;    // FE/ID register holds a word
    hdc_pkg::feid_t payload;
    logic          take;     // Decode writes the word this cycle

    // Fetch side owns the FE/ID register
    modport fe (
        output valid,
        output payload,
        input  take
    );

    // Decode side consumes it
    modport id (
        input  valid,
        input  payload,
        output take
    );

endinterface

/* src/hdc_pkg.sv */
//====================================================================
// Shared field types, fetch and decode payload structs,
// RV32I opcode values and control bit positions
//====================================================================

package hdc_pkg;

    // Field types
    typedef logic [4:0] rf_add_t;   // Register file address
    typedef logic [3:0] f_part_t;   // {instr[30] or 0, funct3}
    typedef logic [2:0] sctrl_t;    // Source control
    typedef logic [6:0] ictrl_t;    // Instruction control
    typedef logic [1:0] imiscon_t;  // Misconduct code

    // Source control bit positions
    localparam int SCTRL_RS1 = 0;   // Reads rs1
    localparam int SCTRL_RS2 = 1;   // Reads rs2
    localparam int SCTRL_IMM = 2;   // Uses the immediate

    // Instruction control bit positions
    localparam int ICTRL_ALU    = 0;
    localparam int ICTRL_LOAD   = 1;
    localparam int ICTRL_STORE  = 2;
    localparam int ICTRL_BRANCH = 3;
    localparam int ICTRL_JUMP   = 4;
    localparam int ICTRL_UPPER  = 5;
    localparam int ICTRL_RD     = 6;   // Writes rd

    // Misconduct codes
    localparam imiscon_t IMISCON_FREE    = 2'b00;
    localparam imiscon_t IMISCON_ILLEGAL = 2'b01;
    localparam imiscon_t IMISCON_BUSERR  = 2'b10;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Word handed from fetch to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        berr;     // Bus error on this fetch
    } feid_t;

    // Decoded instruction held in the ID/OP register
    typedef struct packed {
        logic [31:0] pc;
        rf_add_t     rd;
        rf_add_t     rs1;
        rf_add_t     rs2;
        f_part_t     f;
        logic [31:0] imm;
        sctrl_t      sctrl;
        ictrl_t      ictrl;
        imiscon_t    imiscon;
    } idop_t;

endpackage
